//--- rtl/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    ////////////////////
    // Operation codes
    ////////////////////

    // Op level as held by the pipeline
    typedef logic [3:0] md_op_t;

    // Zero and the unused codes do nothing
    localparam md_op_t MD_NOP   = 4'd0;
    localparam md_op_t MD_DIV   = 4'd1;
    localparam md_op_t MD_DIVU  = 4'd2;
    localparam md_op_t MD_MFHI  = 4'd3;
    localparam md_op_t MD_MFLO  = 4'd4;
    localparam md_op_t MD_MTHI  = 4'd5;
    localparam md_op_t MD_MTLO  = 4'd6;
    // Low word of signed product on the result port only
    localparam md_op_t MD_MUL   = 4'd7;
    localparam md_op_t MD_MULT  = 4'd8;
    localparam md_op_t MD_MULTU = 4'd9;

    ////////////////////
    // Result select
    ////////////////////

    typedef logic [1:0] res_sel_t;

    localparam res_sel_t RES_ZERO = 2'd0;
    localparam res_sel_t RES_HI   = 2'd1;
    localparam res_sel_t RES_LO   = 2'd2;
    localparam res_sel_t RES_MUL  = 2'd3;

    // Data width unless the top level says otherwise
    localparam int MD_XLEN_DEFAULT = 32;

endpackage

`default_nettype wire

//--- rtl/md_decode.sv
`timescale 1ns/10ps
`default_nettype none

module md_decode (
    input  wire                  clk,
    input  wire                  arst_n,
    input  muldiv_pkg::md_op_t   md_op,
    input  wire                  mul_done,
    input  wire                  div_done,
    output logic                 mul_start,
    output logic                 mul_signed,
    output logic                 div_start,
    output logic                 div_signed,
    output logic                 hi_src_mt,
    output logic                 lo_src_mt,
    output logic                 prod_we,
    output muldiv_pkg::res_sel_t res_sel,
    output logic                 md_stall
);

    // Op class
    logic is_mul;
    logic is_div;

    // Unit occupied since its start pulse
    logic mul_busy;
    logic div_busy;

    ////////////////////
    // Op classification
    ////////////////////

    always_comb begin
        is_mul     = 1'b0;
        is_div     = 1'b0;
        mul_signed = 1'b0;
        div_signed = 1'b0;
        hi_src_mt  = 1'b0;
        lo_src_mt  = 1'b0;
        prod_we    = 1'b0;
        res_sel    = muldiv_pkg::RES_ZERO;
        case (md_op)
            muldiv_pkg::MD_DIV: begin
                is_div     = 1'b1;
                div_signed = 1'b1;
            end
            muldiv_pkg::MD_DIVU: is_div = 1'b1;
            muldiv_pkg::MD_MFHI: res_sel = muldiv_pkg::RES_HI;
            muldiv_pkg::MD_MFLO: res_sel = muldiv_pkg::RES_LO;
            muldiv_pkg::MD_MTHI: hi_src_mt = 1'b1;
            muldiv_pkg::MD_MTLO: lo_src_mt = 1'b1;
            muldiv_pkg::MD_MUL: begin
                // Result goes to the port and leaves HI and LO untouched
                is_mul     = 1'b1;
                mul_signed = 1'b1;
                res_sel    = muldiv_pkg::RES_MUL;
            end
            muldiv_pkg::MD_MULT: begin
                is_mul     = 1'b1;
                mul_signed = 1'b1;
                prod_we    = 1'b1;
            end
            muldiv_pkg::MD_MULTU: begin
                is_mul  = 1'b1;
                prod_we = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////
    // Start and stall
    ////////////////////

    // One pulse per instruction and only from an idle unit
    assign mul_start = is_mul & ~mul_busy;
    assign div_start = is_div & ~div_busy;

    // Held until the unit reports done
    assign md_stall = (is_mul & ~mul_done) | (is_div & ~div_done);

    // Busy set on start, cleared on done
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mul_busy <= 1'b0;
            div_busy <= 1'b0;
        end else begin
            if (mul_start)
                mul_busy <= 1'b1;
            else if (mul_done)
                mul_busy <= 1'b0;
            if (div_start)
                div_busy <= 1'b1;
            else if (div_done)
                div_busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/md_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module md_multiplier #(
    parameter int XLEN = muldiv_pkg::MD_XLEN_DEFAULT
) (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 mul_start,
    input  wire                 mul_signed,
    input  wire  [XLEN-1:0]     rs,
    input  wire  [XLEN-1:0]     rt,
    output logic [2*XLEN-1:0]   prod,
    output logic                mul_done
);

    // Operands widened by one bit
    // Top bit is the sign for signed ops, zero otherwise
    logic signed [XLEN:0]     rs_ext;
    logic signed [XLEN:0]     rt_ext;
    logic signed [2*XLEN-1:0] prod_full;

    assign rs_ext = {mul_signed & rs[XLEN-1], rs};
    assign rt_ext = {mul_signed & rt[XLEN-1], rt};

    // Signed multiply covers both cases after extension
    assign prod_full = rs_ext * rt_ext;

    // Product register, loaded only on start
    always_ff @(posedge clk) begin
        if (mul_start)
            prod <= prod_full;
    end

    // Done one cycle after start
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mul_done <= 1'b0;
        else
            mul_done <= mul_start;
    end

endmodule

`default_nettype wire

//--- rtl/md_divider.sv
`timescale 1ns/10ps
`default_nettype none

module md_divider #(
    parameter int XLEN = muldiv_pkg::MD_XLEN_DEFAULT
) (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 div_start,
    input  wire                 div_signed,
    input  wire  [XLEN-1:0]     rs,
    input  wire  [XLEN-1:0]     rt,
    output logic [XLEN-1:0]     quot,
    output logic [XLEN-1:0]     rem,
    output logic                div_done
);

    localparam int CNT_W = $clog2(XLEN + 1);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_SUB,
        DIV_FIX
    } div_state_t;

    // Steps left in the current divide
    typedef logic [CNT_W-1:0] step_cnt_t;

    div_state_t state;
    step_cnt_t  step_cnt;

    // Quotient shift register that starts out holding the dividend magnitude
    logic [XLEN-1:0] quo_q;
    // Partial remainder
    logic [XLEN-1:0] part_rem;
    // Divisor magnitude
    logic [XLEN-1:0] dsr_q;
    // Result signs
    logic            quo_neg;
    logic            rem_neg;

    // Operand signs for signed divides only
    logic            rs_neg;
    logic            rt_neg;

    // One restoring step
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;
    logic            fits;

    assign rs_neg = div_signed & rs[XLEN-1];
    assign rt_neg = div_signed & rt[XLEN-1];

    // Bring down the next dividend bit
    assign shifted = {part_rem, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dsr_q};
    // No borrow means the divisor fits
    assign fits    = ~diff[XLEN];

    ////////////////////
    // Control FSM
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (div_start) begin
                        state    <= DIV_SUB;
                        step_cnt <= step_cnt_t'(XLEN);
                    end
                end
                DIV_SUB: begin
                    step_cnt <= step_cnt - step_cnt_t'(1);
                    // Last step this cycle
                    if (step_cnt == step_cnt_t'(1))
                        state <= DIV_FIX;
                end
                DIV_FIX: state <= DIV_IDLE;
                default: state <= DIV_IDLE;
            endcase
        end
    end

    ////////////////////
    // Datapath
    ////////////////////

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && div_start) begin
            // Magnitudes in and signs kept aside
            quo_q    <= rs_neg ? -rs : rs;
            dsr_q    <= rt_neg ? -rt : rt;
            part_rem <= '0;
            quo_neg  <= rs_neg ^ rt_neg;
            rem_neg  <= rs_neg;
        end else if (state == DIV_SUB) begin
            quo_q    <= {quo_q[XLEN-2:0], fits};
            part_rem <= fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
        end
    end

    // Zero divisor always fits, so the quotient ends up all ones
    // and the remainder is the dividend magnitude

    // Signs applied on the way out and valid in the fix state
    assign quot     = quo_neg ? -quo_q : quo_q;
    assign rem      = rem_neg ? -part_rem : part_rem;
    assign div_done = (state == DIV_FIX);

endmodule

`default_nettype wire

//--- rtl/md_hilo.sv
`timescale 1ns/10ps
`default_nettype none

module md_hilo #(
    parameter int XLEN = muldiv_pkg::MD_XLEN_DEFAULT
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   hi_src_mt,
    input  wire                   lo_src_mt,
    input  wire                   prod_we,
    input  wire                   mul_done,
    input  wire                   div_done,
    input  muldiv_pkg::res_sel_t  res_sel,
    input  wire  [XLEN-1:0]       rs,
    input  wire  [2*XLEN-1:0]     prod,
    input  wire  [XLEN-1:0]       quot,
    input  wire  [XLEN-1:0]       rem,
    output logic [XLEN-1:0]       res_out
);

    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;

    // Product lands in HI and LO only for MULT and MULTU
    logic prod_wr;

    assign prod_wr = prod_we & mul_done;

    ////////////////////
    // HI and LO
    ////////////////////

    // Move-to first, then product, then divide result
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (hi_src_mt)
                hi <= rs;
            else if (prod_wr)
                hi <= prod[2*XLEN-1:XLEN];
            else if (div_done)
                hi <= rem;

            if (lo_src_mt)
                lo <= rs;
            else if (prod_wr)
                lo <= prod[XLEN-1:0];
            else if (div_done)
                lo <= quot;
        end
    end

    ////////////////////
    // Result port
    ////////////////////

    always_comb begin
        case (res_sel)
            muldiv_pkg::RES_HI:  res_out = hi;
            muldiv_pkg::RES_LO:  res_out = lo;
            // Low word for MUL
            muldiv_pkg::RES_MUL: res_out = prod[XLEN-1:0];
            default:             res_out = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/muldiv_unit.sv
`timescale 1ns/10ps
`default_nettype none

module muldiv_unit #(
    parameter int XLEN = muldiv_pkg::MD_XLEN_DEFAULT
) (
    input  wire                 clk,
    input  wire                 arst_n,
    input  muldiv_pkg::md_op_t  md_op,
    input  wire  [XLEN-1:0]     rs,
    input  wire  [XLEN-1:0]     rt,
    output logic [XLEN-1:0]     res_out,
    output logic                md_stall
);

    // Decode to units
    logic                 mul_start;
    logic                 mul_signed;
    logic                 div_start;
    logic                 div_signed;
    logic                 hi_src_mt;
    logic                 lo_src_mt;
    logic                 prod_we;
    muldiv_pkg::res_sel_t res_sel;

    // Units back to decode and HI/LO
    logic                 mul_done;
    logic                 div_done;
    logic [2*XLEN-1:0]    prod;
    logic [XLEN-1:0]      quot;
    logic [XLEN-1:0]      rem;

    md_decode u_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .md_op      (md_op),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .mul_start  (mul_start),
        .mul_signed (mul_signed),
        .div_start  (div_start),
        .div_signed (div_signed),
        .hi_src_mt  (hi_src_mt),
        .lo_src_mt  (lo_src_mt),
        .prod_we    (prod_we),
        .res_sel    (res_sel),
        .md_stall   (md_stall)
    );

    // Single-cycle product
    md_multiplier #(.XLEN(XLEN)) u_multiplier (
        .clk        (clk),
        .arst_n     (arst_n),
        .mul_start  (mul_start),
        .mul_signed (mul_signed),
        .rs         (rs),
        .rt         (rt),
        .prod       (prod),
        .mul_done   (mul_done)
    );

    // One quotient bit per clock
    md_divider #(.XLEN(XLEN)) u_divider (
        .clk        (clk),
        .arst_n     (arst_n),
        .div_start  (div_start),
        .div_signed (div_signed),
        .rs         (rs),
        .rt         (rt),
        .quot       (quot),
        .rem        (rem),
        .div_done   (div_done)
    );

    md_hilo #(.XLEN(XLEN)) u_hilo (
        .clk        (clk),
        .arst_n     (arst_n),
        .hi_src_mt  (hi_src_mt),
        .lo_src_mt  (lo_src_mt),
        .prod_we    (prod_we),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .res_sel    (res_sel),
        .rs         (rs),
        .prod       (prod),
        .quot       (quot),
        .rem        (rem),
        .res_out    (res_out)
    );

endmodule

`default_nettype wire

//--- sim/tb_muldiv_tests.svh
////////////////////
// Move to and from
////////////////////

task automatic move_to_from();
    string name;
    int    stalls;
    word_t result;
    word_t hi;
    word_t lo;
    name = "move_to_from";
    start_test();
    // Idle unit straight out of reset
    run_op(name, muldiv_pkg::MD_NOP, 32'h1357_9bdf, 32'h2468_ace0, stalls, result);
    if (result !== '0)
        report_mismatch(name, "NOP res_out", '0, result);
    if (stalls != 0)
        report_mismatch(name, "NOP stall cycles", 0, stalls);
    run_op(name, muldiv_pkg::MD_MTHI, 32'hdead_beef, 32'h1111_1111, stalls, result);
    if (stalls != 0)
        report_mismatch(name, "MTHI stall cycles", 0, stalls);
    run_op(name, muldiv_pkg::MD_MTLO, 32'h0bad_cafe, 32'h2222_2222, stalls, result);
    if (stalls != 0)
        report_mismatch(name, "MTLO stall cycles", 0, stalls);
    read_hilo(name, hi, lo);
    if (hi !== 32'hdead_beef)
        report_mismatch(name, "HI", 32'hdead_beef, hi);
    if (lo !== 32'h0bad_cafe)
        report_mismatch(name, "LO", 32'h0bad_cafe, lo);
    finish_test(name);
endtask

////////////////////
// Products
////////////////////

task automatic mult_case(string name, muldiv_pkg::md_op_t op, word_t a, word_t b);
    int                stalls;
    word_t             result;
    word_t             hi;
    word_t             lo;
    logic [2*XLEN-1:0] expected;
    expected = mul_ref(a, b, op == muldiv_pkg::MD_MULT);
    run_op(name, op, a, b, stalls, result);
    if (stalls != MUL_STALL)
        report_mismatch(name, "stall cycles", MUL_STALL, stalls);
    read_hilo(name, hi, lo);
    if (hi !== expected[2*XLEN-1:XLEN])
        report_mismatch(name, "HI", expected[2*XLEN-1:XLEN], hi);
    if (lo !== expected[XLEN-1:0])
        report_mismatch(name, "LO", expected[XLEN-1:0], lo);
endtask

// Same operands signed and then unsigned
task automatic mult_pair(string name, word_t a, word_t b);
    mult_case(name, muldiv_pkg::MD_MULT, a, b);
    mult_case(name, muldiv_pkg::MD_MULTU, a, b);
endtask

task automatic mult_products();
    string name;
    word_t a;
    word_t b;
    name = "mult_products";
    start_test();
    mult_pair(name, 32'h8000_0000, 32'h8000_0000);
    mult_pair(name, 32'h7fff_ffff, 32'h8000_0000);
    mult_pair(name, 32'hffff_ffff, 32'hffff_ffff);
    mult_pair(name, 32'hffff_ffff, 32'h0000_0001);
    mult_pair(name, 32'h1234_5678, 32'h0000_0000);
    for (int i = 0; i < 6; i++) begin
        a = $random(seed);
        b = $random(seed);
        mult_pair(name, a, b);
    end
    finish_test(name);
endtask

// MUL result on the port only
task automatic mul_case(string name, word_t a, word_t b);
    int                stalls;
    word_t             result;
    logic [2*XLEN-1:0] expected;
    expected = mul_ref(a, b, 1'b1);
    run_op(name, muldiv_pkg::MD_MUL, a, b, stalls, result);
    if (stalls != MUL_STALL)
        report_mismatch(name, "stall cycles", MUL_STALL, stalls);
    if (result !== expected[XLEN-1:0])
        report_mismatch(name, "res_out", expected[XLEN-1:0], result);
endtask

task automatic mul_low_word();
    string name;
    int    stalls;
    word_t result;
    word_t hi;
    word_t lo;
    name = "mul_low_word";
    start_test();
    // Known HI and LO that MUL must leave alone
    run_op(name, muldiv_pkg::MD_MTHI, 32'h5a5a_0001, '0, stalls, result);
    run_op(name, muldiv_pkg::MD_MTLO, 32'ha5a5_0002, '0, stalls, result);
    mul_case(name, 32'hffff_fffd, 32'h0000_0007);
    mul_case(name, 32'h8000_0000, 32'hffff_ffff);
    mul_case(name, $random(seed), $random(seed));
    mul_case(name, $random(seed), $random(seed));
    read_hilo(name, hi, lo);
    if (hi !== 32'h5a5a_0001)
        report_mismatch(name, "HI after MUL", 32'h5a5a_0001, hi);
    if (lo !== 32'ha5a5_0002)
        report_mismatch(name, "LO after MUL", 32'ha5a5_0002, lo);
    finish_test(name);
endtask

////////////////////
// Divides
////////////////////

task automatic div_case(string name, muldiv_pkg::md_op_t op, word_t a, word_t b);
    int                stalls;
    word_t             result;
    word_t             hi;
    word_t             lo;
    logic [2*XLEN-1:0] expected;
    expected = div_ref(a, b, op == muldiv_pkg::MD_DIV);
    run_op(name, op, a, b, stalls, result);
    if (stalls != DIV_STALL)
        report_mismatch(name, "stall cycles", DIV_STALL, stalls);
    read_hilo(name, hi, lo);
    // Remainder in HI and quotient in LO
    if (hi !== expected[2*XLEN-1:XLEN])
        report_mismatch(name, "HI", expected[2*XLEN-1:XLEN], hi);
    if (lo !== expected[XLEN-1:0])
        report_mismatch(name, "LO", expected[XLEN-1:0], lo);
endtask

task automatic div_results();
    string name;
    word_t a;
    word_t b;
    name = "div_results";
    start_test();
    // Sign combinations of 100 and 7
    div_case(name, muldiv_pkg::MD_DIV, 32'd100, 32'd7);
    div_case(name, muldiv_pkg::MD_DIV, 32'hffff_ff9c, 32'd7);
    div_case(name, muldiv_pkg::MD_DIV, 32'd100, 32'hffff_fff9);
    div_case(name, muldiv_pkg::MD_DIV, 32'hffff_ff9c, 32'hffff_fff9);
    div_case(name, muldiv_pkg::MD_DIV, 32'h8000_0000, 32'hffff_ffff);
    // Zero divisor
    div_case(name, muldiv_pkg::MD_DIV, 32'h1234_5678, 32'd0);
    div_case(name, muldiv_pkg::MD_DIV, 32'hffff_ff9c, 32'd0);
    div_case(name, muldiv_pkg::MD_DIVU, 32'hffff_ffff, 32'd3);
    div_case(name, muldiv_pkg::MD_DIVU, 32'h8000_0000, 32'hffff_ffff);
    div_case(name, muldiv_pkg::MD_DIVU, 32'h0000_1234, 32'd0);
    for (int i = 0; i < 4; i++) begin
        a = $random(seed);
        b = $random(seed);
        // Narrower divisors give longer quotients
        b = b >> (6 * i);
        div_case(name, muldiv_pkg::MD_DIV, a, b);
        div_case(name, muldiv_pkg::MD_DIVU, a, b);
    end
    finish_test(name);
endtask

////////////////////
// Back to back
////////////////////

task automatic back_to_back_ops();
    string             name;
    int                stalls;
    word_t             result;
    word_t             hi;
    word_t             lo;
    logic [2*XLEN-1:0] expected;
    name = "back_to_back_ops";
    start_test();
    // Two DIVs with no NOP between them and -999 / 10 as the second
    run_op(name, muldiv_pkg::MD_DIV, 32'd1000, 32'd7, stalls, result);
    if (stalls != DIV_STALL)
        report_mismatch(name, "first DIV stall cycles", DIV_STALL, stalls);
    run_op(name, muldiv_pkg::MD_DIV, 32'hffff_fc19, 32'd10, stalls, result);
    if (stalls != DIV_STALL)
        report_mismatch(name, "second DIV stall cycles", DIV_STALL, stalls);
    read_hilo(name, hi, lo);
    expected = div_ref(32'hffff_fc19, 32'd10, 1'b1);
    if (hi !== expected[2*XLEN-1:XLEN])
        report_mismatch(name, "DIV HI", expected[2*XLEN-1:XLEN], hi);
    if (lo !== expected[XLEN-1:0])
        report_mismatch(name, "DIV LO", expected[XLEN-1:0], lo);
    // Two MULTs whose operands change with the op held
    run_op(name, muldiv_pkg::MD_MULT, 32'h0001_0003, 32'hffff_0005, stalls, result);
    if (stalls != MUL_STALL)
        report_mismatch(name, "first MULT stall cycles", MUL_STALL, stalls);
    run_op(name, muldiv_pkg::MD_MULT, 32'h7654_3210, 32'h0000_0123, stalls, result);
    if (stalls != MUL_STALL)
        report_mismatch(name, "second MULT stall cycles", MUL_STALL, stalls);
    read_hilo(name, hi, lo);
    expected = mul_ref(32'h7654_3210, 32'h0000_0123, 1'b1);
    if (hi !== expected[2*XLEN-1:XLEN])
        report_mismatch(name, "MULT HI", expected[2*XLEN-1:XLEN], hi);
    if (lo !== expected[XLEN-1:0])
        report_mismatch(name, "MULT LO", expected[XLEN-1:0], lo);
    finish_test(name);
endtask

//--- sim/tb_muldiv.sv
`timescale 1ns/10ps
`default_nettype none

module tb_muldiv;

    localparam int XLEN       = 32;
    // Stall length per op class
    localparam int MUL_STALL  = 1;
    localparam int DIV_STALL  = XLEN + 1;
    // Cycle limit for any wait on md_stall
    localparam int WAIT_LIMIT = 100;

    typedef logic [XLEN-1:0] word_t;

    logic               clk;
    logic               arst_n;
    muldiv_pkg::md_op_t md_op;
    word_t              rs;
    word_t              rt;
    word_t              res_out;
    logic               md_stall;

    // Bookkeeping
    integer seed;
    int     test_count;
    int     test_fail;
    int     error_count;
    int     errors_at_start;

    // 10 ns clock
    initial clk = 1'b0;
    always #5 clk = ~clk;

    muldiv_unit #(.XLEN(XLEN)) UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .md_op    (md_op),
        .rs       (rs),
        .rt       (rt),
        .res_out  (res_out),
        .md_stall (md_stall)
    );

    ////////////////////
    // Reference model
    ////////////////////

    // Full product with operands extended by the op's signedness
    function automatic logic [2*XLEN-1:0] mul_ref(word_t a, word_t b, logic sgn);
        logic [2*XLEN-1:0] wide_a;
        logic [2*XLEN-1:0] wide_b;
        wide_a = {{XLEN{sgn & a[XLEN-1]}}, a};
        wide_b = {{XLEN{sgn & b[XLEN-1]}}, b};
        // Low 2*XLEN bits of the two's complement product
        return wide_a * wide_b;
    endfunction

    // Divide rule, packed as {remainder, quotient}
    function automatic logic [2*XLEN-1:0] div_ref(word_t a, word_t b, logic sgn);
        logic  neg_a;
        logic  neg_b;
        word_t mag_a;
        word_t mag_b;
        word_t mag_q;
        word_t mag_r;
        neg_a = sgn & a[XLEN-1];
        neg_b = sgn & b[XLEN-1];
        mag_a = neg_a ? -a : a;
        mag_b = neg_b ? -b : b;
        if (mag_b == '0) begin
            // Zero divisor gives all ones and leaves the dividend over
            mag_q = '1;
            mag_r = mag_a;
        end else begin
            mag_q = mag_a / mag_b;
            mag_r = mag_a % mag_b;
        end
        return {neg_a ? -mag_r : mag_r, (neg_a ^ neg_b) ? -mag_q : mag_q};
    endfunction

    ////////////////////
    // Driving and reporting
    ////////////////////

    task automatic report_mismatch(string test, string what, word_t expected, word_t actual);
        $display("MISMATCH %s: %s expected 0x%h actual 0x%h", test, what, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(string test, string msg);
        $display("ERROR %s: %s", test, msg);
        error_count++;
    endtask

    // New op level just after the rising edge
    task automatic drive_op(muldiv_pkg::md_op_t op, word_t a, word_t b);
        @(posedge clk);
        #1;
        md_op = op;
        rs    = a;
        rt    = b;
    endtask

    // Present an op, count stalled cycles and grab res_out once the stall is low
    task automatic run_op(string test, muldiv_pkg::md_op_t op, word_t a, word_t b,
                          output int stalls, output word_t result);
        drive_op(op, a, b);
        stalls = 0;
        @(negedge clk);
        while (md_stall !== 1'b0 && stalls < WAIT_LIMIT) begin
            stalls++;
            @(negedge clk);
        end
        if (md_stall !== 1'b0)
            report_failure(test, $sformatf("md_stall still high after %0d cycles", WAIT_LIMIT));
        result = res_out;
    endtask

    // MFHI then MFLO
    task automatic read_hilo(string test, output word_t hi, output word_t lo);
        int stalls;
        run_op(test, muldiv_pkg::MD_MFHI, '0, '0, stalls, hi);
        if (stalls != 0)
            report_mismatch(test, "MFHI stall cycles", 0, stalls);
        run_op(test, muldiv_pkg::MD_MFLO, '0, '0, stalls, lo);
        if (stalls != 0)
            report_mismatch(test, "MFLO stall cycles", 0, stalls);
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(string test);
        test_count++;
        if (error_count != errors_at_start) begin
            test_fail++;
            $display("%s: failed with %0d errors", test, error_count - errors_at_start);
        end else begin
            $display("%s: ok", test);
        end
    endtask

    `include "tb_muldiv_tests.svh"

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        md_op       = muldiv_pkg::MD_NOP;
        rs          = '0;
        rt          = '0;
        arst_n      = 1'b0;
        seed        = 32'h1264_98ae;
        test_count  = 0;
        test_fail   = 0;
        error_count = 0;
        // Reset for 4 cycles
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        move_to_from();
        mult_products();
        mul_low_word();
        div_results();
        back_to_back_ops();

        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 test_count, test_fail, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+sim
rtl/muldiv_pkg.sv
rtl/md_decode.sv
rtl/md_multiplier.sv
rtl/md_divider.sv
rtl/md_hilo.sv
rtl/muldiv_unit.sv
sim/tb_muldiv.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the muldiv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_muldiv \
    -Mdir obj_dir \
    -f files.f

output=$(./obj_dir/Vtb_muldiv)
echo "$output"

if echo "$output" | grep -q "^TESTS PASSED$"; then
    exit 0
else
    exit 1
fi
